// File: stream_pkg.sv
package stream_pkg;

   // stored and streamed word
   localparam int DATA_W = 32;

   // word address, 1024-word memory
   localparam int ADDR_W = 10;

   // period and duty counts
   localparam int PERIOD_W = 10;

   // start delay count
   localparam int DELAY_W = 7;

   // one write strobe per byte lane
   localparam int STRB_W = DATA_W / 8;

   // run configuration, captured by the address generator on an accepted run
   typedef struct packed {
      // number of periods in the run
      logic [ADDR_W-1:0]   iter;
      // cycles per period
      logic [PERIOD_W-1:0] per;
      // leading cycles of each period that issue a read
      logic [PERIOD_W-1:0] duty;
      // address of the first read
      logic [ADDR_W-1:0]   start;
      // base step between periods
      logic [ADDR_W-1:0]   shift;
      // address step inside a period
      logic [ADDR_W-1:0]   incr;
      // idle cycles between run and the first address
      logic [DELAY_W-1:0]  delay;
   } gen_cfg_t;

endpackage

// File: mem_port_if.sv
`timescale 1ns/1ps

interface mem_port_if import stream_pkg::*; ();

   // write side, registered host writes
   logic [ADDR_W-1:0] wr_addr;
   logic              wr_en;
   logic [DATA_W-1:0] wr_data;

   // read side, driven by the address generator
   logic [ADDR_W-1:0] rd_addr;
   logic              rd_en;
   logic [DATA_W-1:0] rd_data;

   modport unit (
      output wr_addr,
      output wr_en,
      output wr_data,
      output rd_addr,
      output rd_en,
      input  rd_data
   );

   modport ram (
      input  wr_addr,
      input  wr_en,
      input  wr_data,
      input  rd_addr,
      input  rd_en,
      output rd_data
   );

endinterface

// File: addr_gen.sv
`timescale 1ns/1ps

module addr_gen import stream_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   input  logic              start_i,
   input  gen_cfg_t          cfg_i,
   output logic              rd_en_o,
   output logic [ADDR_W-1:0] rd_addr_o,
   output logic              done_o
);

   typedef enum logic [1:0] {
      st_idle,
      st_delay,
      st_walk
   } state_t;

   state_t              state_q;
   gen_cfg_t            cfg_q;
   logic [DELAY_W-1:0]  delay_cnt_q;
   logic [ADDR_W-1:0]   iter_cnt_q;
   logic [PERIOD_W-1:0] per_cnt_q;
   logic [ADDR_W-1:0]   base_q;
   logic [ADDR_W-1:0]   addr_q;
   logic                done_q;

   logic                accept;
   logic                empty;
   logic                per_last;
   logic                iter_last;
   logic [ADDR_W-1:0]   next_base;

   // a run pulse only counts while idle
   assign accept = start_i && (state_q == st_idle);

   // zero iterations or zero period length walk a single silent cycle
   assign empty     = (cfg_q.iter == '0) || (cfg_q.per == '0);
   assign per_last  = per_cnt_q == cfg_q.per - 1'b1;
   assign iter_last = iter_cnt_q == cfg_q.iter - 1'b1;
   assign next_base = base_q + cfg_q.shift;

   // configuration stays fixed for the whole run
   always_ff @(posedge clk) begin
      if (accept) begin
         cfg_q <= cfg_i;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q     <= st_idle;
         delay_cnt_q <= '0;
         iter_cnt_q  <= '0;
         per_cnt_q   <= '0;
         base_q      <= '0;
         addr_q      <= '0;
         done_q      <= 1'b1;
      end else begin
         case (state_q)
            st_idle: begin
               if (accept) begin
                  done_q      <= 1'b0;
                  delay_cnt_q <= cfg_i.delay - 1'b1;
                  iter_cnt_q  <= '0;
                  per_cnt_q   <= '0;
                  base_q      <= cfg_i.start;
                  addr_q      <= cfg_i.start;
                  state_q     <= (cfg_i.delay == '0) ? st_walk : st_delay;
               end
            end
            st_delay: begin
               // leaves at edge run+delay
               if (delay_cnt_q == '0) begin
                  state_q <= st_walk;
               end else begin
                  delay_cnt_q <= delay_cnt_q - 1'b1;
               end
            end
            st_walk: begin
               if (empty || (per_last && iter_last)) begin
                  done_q  <= 1'b1;
                  state_q <= st_idle;
               end else if (per_last) begin
                  // next iteration restarts from the shifted base
                  per_cnt_q  <= '0;
                  iter_cnt_q <= iter_cnt_q + 1'b1;
                  base_q     <= next_base;
                  addr_q     <= next_base;
               end else begin
                  per_cnt_q <= per_cnt_q + 1'b1;
                  addr_q    <= addr_q + cfg_q.incr;
               end
            end
            default: begin
               state_q <= st_idle;
            end
         endcase
      end
   end

   // duty gates the leading cycles of each period
   assign rd_en_o   = (state_q == st_walk) && !empty && (per_cnt_q < cfg_q.duty);
   assign rd_addr_o = addr_q;
   assign done_o    = done_q;

endmodule

// File: out_mem_unit.sv
`timescale 1ns/1ps

module out_mem_unit import stream_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   input  logic              running_i,
   input  logic              run_i,
   input  logic              disabled_i,
   output logic              done_o,
   input  logic [STRB_W-1:0] wstrb_i,
   input  logic [ADDR_W-1:0] addr_i,
   input  logic [DATA_W-1:0] wdata_i,
   input  logic              valid_i,
   input  gen_cfg_t          cfg_i,
   output logic [DATA_W-1:0] out_o,
   mem_port_if.unit          mem
);

   logic              gen_start;
   logic              gen_en;
   logic [ADDR_W-1:0] gen_addr;

   logic [ADDR_W-1:0] wr_addr_q;
   logic [DATA_W-1:0] wr_data_q;
   logic              wr_en_q;
   logic [DATA_W-1:0] out_q;

   // a disabled unit ignores run
   assign gen_start = run_i && !disabled_i;

   addr_gen u_gen (
      .clk       (clk),
      .rst       (rst),
      .start_i   (gen_start),
      .cfg_i     (cfg_i),
      .rd_en_o   (gen_en),
      .rd_addr_o (gen_addr),
      .done_o    (done_o)
   );

   // host write payload, one cycle ahead of the memory
   always_ff @(posedge clk) begin
      wr_addr_q <= addr_i;
      wr_data_q <= wdata_i;
   end

   // any strobe writes the full word
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_en_q <= 1'b0;
      end else begin
         wr_en_q <= valid_i && (|wstrb_i);
      end
   end

   assign mem.wr_addr = wr_addr_q;
   assign mem.wr_data = wr_data_q;
   assign mem.wr_en   = wr_en_q;

   assign mem.rd_addr = gen_addr;
   assign mem.rd_en   = gen_en;

   // output stage, reloads every cycle
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         out_q <= '0;
      end else begin
         out_q <= mem.rd_data;
      end
   end

   assign out_o = running_i ? out_q : '0;

endmodule

// File: dp_ram.sv
`timescale 1ns/1ps

module dp_ram import stream_pkg::*; (
   input  logic     clk,
   input  logic     rst,
   mem_port_if.ram  mem
);

   logic [DATA_W-1:0] ram_q [2**ADDR_W];
   logic [DATA_W-1:0] rd_q;

   always_ff @(posedge clk) begin
      if (mem.wr_en) begin
         ram_q[mem.wr_addr] <= mem.wr_data;
      end
   end

   // same-address read and write in one cycle returns the old word
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_q <= '0;
      end else if (mem.rd_en) begin
         rd_q <= ram_q[mem.rd_addr];
      end
   end

   // holds the last word while rd_en is low
   assign mem.rd_data = rd_q;

endmodule

// File: stream_top.sv
`timescale 1ns/1ps

module stream_top import stream_pkg::*; (
   input  logic                clk,
   input  logic                rst,
   input  logic                running_i,
   input  logic                run_i,
   input  logic                disabled_i,
   output logic                done_o,
   input  logic [STRB_W-1:0]   wstrb_i,
   input  logic [ADDR_W-1:0]   addr_i,
   input  logic [DATA_W-1:0]   wdata_i,
   input  logic                valid_i,
   input  logic [ADDR_W-1:0]   iter_i,
   input  logic [PERIOD_W-1:0] per_i,
   input  logic [PERIOD_W-1:0] duty_i,
   input  logic [ADDR_W-1:0]   start_i,
   input  logic [ADDR_W-1:0]   shift_i,
   input  logic [ADDR_W-1:0]   incr_i,
   input  logic [DELAY_W-1:0]  delay_i,
   output logic [DATA_W-1:0]   out_o
);

   gen_cfg_t cfg;

   mem_port_if mem_if ();

   // configuration fields packed in struct order
   assign cfg = '{
      iter:  iter_i,
      per:   per_i,
      duty:  duty_i,
      start: start_i,
      shift: shift_i,
      incr:  incr_i,
      delay: delay_i
   };

   out_mem_unit u_unit (
      .clk        (clk),
      .rst        (rst),
      .running_i  (running_i),
      .run_i      (run_i),
      .disabled_i (disabled_i),
      .done_o     (done_o),
      .wstrb_i    (wstrb_i),
      .addr_i     (addr_i),
      .wdata_i    (wdata_i),
      .valid_i    (valid_i),
      .cfg_i      (cfg),
      .out_o      (out_o),
      .mem        (mem_if.unit)
   );

   dp_ram u_ram (
      .clk (clk),
      .rst (rst),
      .mem (mem_if.ram)
   );

endmodule

// File: tb_stream_asserts.sv
`timescale 1ns/1ps

module tb_stream_asserts import stream_pkg::*; (
   input logic              clk,
   input logic              rst,
   input logic              start_i,
   input logic              done_i,
   input logic              rd_en_i,
   input logic              valid_i,
   input logic [STRB_W-1:0] wstrb_i,
   input logic              wr_en_i
);

   // no reads once the generator is idle
   a_no_read_when_done: assert property (@(posedge clk) disable iff (rst)
      !(rd_en_i && done_i))
      else $error("read enable high while done is high");

   a_wr_en_follows: assert property (@(posedge clk) disable iff (rst)
      (valid_i && (|wstrb_i)) |=> wr_en_i)
      else $error("write enable missing one cycle after a host write");

   a_no_spurious_wr: assert property (@(posedge clk) disable iff (rst)
      !(valid_i && (|wstrb_i)) |=> !wr_en_i)
      else $error("write enable without a host write");

   a_done_holds: assert property (@(posedge clk) disable iff (rst)
      (done_i && !start_i) |=> done_i)
      else $error("done fell without an accepted run");

endmodule

bind out_mem_unit tb_stream_asserts u_asserts (
   .clk     (clk),
   .rst     (rst),
   .start_i (gen_start),
   .done_i  (done_o),
   .rd_en_i (gen_en),
   .valid_i (valid_i),
   .wstrb_i (wstrb_i),
   .wr_en_i (wr_en_q)
);

// File: tb_stream.sv
`timescale 1ns/1ps

module tb_stream import stream_pkg::*; ();

   localparam logic [31:0] SEED = 32'hd9511633;
   localparam int N_RAND = 60;
   // longest run: delay, walk, output latency and a disabled pulse
   localparam int RUN_MAX = 64;
   localparam int TIMEOUT_CYC = 16 + 2 * (2 ** ADDR_W) + (N_RAND + 12) * RUN_MAX;

   logic                clk = 1'b0;
   logic                rst;
   logic                running_i;
   logic                run_i;
   logic                disabled_i;
   logic                done_o;
   logic [STRB_W-1:0]   wstrb_i;
   logic [ADDR_W-1:0]   addr_i;
   logic [DATA_W-1:0]   wdata_i;
   logic                valid_i;
   logic [ADDR_W-1:0]   iter_i;
   logic [PERIOD_W-1:0] per_i;
   logic [PERIOD_W-1:0] duty_i;
   logic [ADDR_W-1:0]   start_i;
   logic [ADDR_W-1:0]   shift_i;
   logic [ADDR_W-1:0]   incr_i;
   logic [DELAY_W-1:0]  delay_i;
   logic [DATA_W-1:0]   out_o;

   // memory and stream model
   logic [DATA_W-1:0] mem_m [2**ADDR_W];
   logic [DATA_W-1:0] rd_m;
   logic [DATA_W-1:0] out_m;
   logic              done_m;
   // host write in flight: register stage, then the RAM write
   logic              p0_en;
   logic [ADDR_W-1:0] p0_a;
   logic [DATA_W-1:0] p0_d;
   logic              p1_en;
   logic [ADDR_W-1:0] p1_a;
   logic [DATA_W-1:0] p1_d;
   // active run, edges counted from the one that samples run
   bit                act;
   int                m;
   int                c_iter;
   int                c_per;
   int                c_duty;
   int                c_start;
   int                c_shift;
   int                c_incr;
   int                c_delay;

   stream_top i_dut (
      .clk        (clk),
      .rst        (rst),
      .running_i  (running_i),
      .run_i      (run_i),
      .disabled_i (disabled_i),
      .done_o     (done_o),
      .wstrb_i    (wstrb_i),
      .addr_i     (addr_i),
      .wdata_i    (wdata_i),
      .valid_i    (valid_i),
      .iter_i     (iter_i),
      .per_i      (per_i),
      .duty_i     (duty_i),
      .start_i    (start_i),
      .shift_i    (shift_i),
      .incr_i     (incr_i),
      .delay_i    (delay_i),
      .out_o      (out_o)
   );

   always #5 clk = ~clk;

   // an empty walk still spends one cycle
   function automatic int walk_len();
      if (c_iter == 0 || c_per == 0) begin
         return 1;
      end
      return c_iter * c_per;
   endfunction

   function automatic bit reads_at(int t);
      if (c_iter == 0 || c_per == 0 || t < 0 || t >= c_iter * c_per) begin
         return 1'b0;
      end
      return (t % c_per) < c_duty;
   endfunction

   function automatic logic [ADDR_W-1:0] addr_at(int t);
      int a;
      a = c_start + (t / c_per) * c_shift + (t % c_per) * c_incr;
      return a[ADDR_W-1:0];
   endfunction

   task automatic set_cfg(int it, int pe, int du, int st, int sh, int inc, int de);
      c_iter  = it;
      c_per   = pe;
      c_duty  = du;
      c_start = st;
      c_shift = sh;
      c_incr  = inc;
      c_delay = de;
   endtask

   // rising edge: drop strobes, advance the model by one clock
   task automatic edge_update();
      int t;
      @(posedge clk);
      run_i   <= 1'b0;
      valid_i <= 1'b0;
      out_m = rd_m;
      if (act) begin
         t = m - 1 - c_delay;
         if (reads_at(t)) begin
            rd_m = mem_m[addr_at(t)];
         end
         if (m == 0) begin
            done_m = 1'b0;
         end else if (m == c_delay + walk_len()) begin
            done_m = 1'b1;
         end else if (m > c_delay + walk_len()) begin
            act = 1'b0;
         end
         m++;
      end
      // read above sees the old word on a collision
      if (p1_en) begin
         mem_m[p1_a] = p1_d;
      end
      p1_en = p0_en;
      p1_a  = p0_a;
      p1_d  = p0_d;
      p0_en = 1'b0;
   endtask

   task automatic check_outputs();
      logic [DATA_W-1:0] exp_out;
      @(negedge clk);
      exp_out = running_i ? out_m : '0;
      assert (done_o === done_m) else begin
         $display("error: time %0t, done_o expected %0b, actual %0b", $time, done_m, done_o);
         $display("Testbench failed");
         $fatal(1, "done_o does not match the model");
      end
      assert (out_o === exp_out) else begin
         $display("error: time %0t, out_o expected %h, actual %h", $time, exp_out, out_o);
         $display("Testbench failed");
         $fatal(1, "out_o does not match the model");
      end
   endtask

   task automatic idle_cycles(int n);
      repeat (n) begin
         edge_update();
         check_outputs();
      end
   endtask

   task automatic host_write(logic [ADDR_W-1:0] a, logic [DATA_W-1:0] d,
                             logic [STRB_W-1:0] strb);
      valid_i <= 1'b1;
      addr_i  <= a;
      wdata_i <= d;
      wstrb_i <= strb;
      if (strb != '0) begin
         p0_en = 1'b1;
         p0_a  = a;
         p0_d  = d;
      end
   endtask

   task automatic do_run(bit dis, bit busy, bit wr_mid, bit run_lvl);
      int                t;
      int                wm;
      logic [ADDR_W-1:0] wa;
      wm = -1;
      wa = '0;
      if (wr_mid) begin
         t  = int'($urandom_range(walk_len() - 1, 0));
         wa = reads_at(t) ? addr_at(t) : ADDR_W'($urandom);
         // lands one cycle before the read, or on the same edge
         wm = c_delay + t - 1 - int'($urandom_range(1, 0));
      end
      edge_update();
      run_i      <= 1'b1;
      disabled_i <= dis;
      running_i  <= run_lvl;
      iter_i     <= ADDR_W'(c_iter);
      per_i      <= PERIOD_W'(c_per);
      duty_i     <= PERIOD_W'(c_duty);
      start_i    <= ADDR_W'(c_start);
      shift_i    <= ADDR_W'(c_shift);
      incr_i     <= ADDR_W'(c_incr);
      delay_i    <= DELAY_W'(c_delay);
      if (!dis) begin
         act = 1'b1;
         m   = 0;
      end
      check_outputs();
      if (dis) begin
         edge_update();
         disabled_i <= 1'b0;
         check_outputs();
         idle_cycles(3);
      end
      while (act) begin
         edge_update();
         if (busy && m == 1) begin
            // second pulse with a different configuration
            run_i   <= 1'b1;
            start_i <= ADDR_W'($urandom);
            delay_i <= DELAY_W'($urandom);
         end
         if (m - 1 == wm) begin
            host_write(wa, $urandom, '1);
         end
         check_outputs();
      end
   endtask

   initial begin
      void'($urandom(SEED));
      rst        = 1'b1;
      running_i  = 1'b1;
      run_i      = 1'b0;
      disabled_i = 1'b0;
      valid_i    = 1'b0;
      wstrb_i    = '0;
      addr_i     = '0;
      wdata_i    = '0;
      iter_i     = '0;
      per_i      = '0;
      duty_i     = '0;
      start_i    = '0;
      shift_i    = '0;
      incr_i     = '0;
      delay_i    = '0;
      rd_m       = '0;
      out_m      = '0;
      done_m     = 1'b1;
      p0_en      = 1'b0;
      p1_en      = 1'b0;
      act        = 1'b0;
      repeat (16) @(posedge clk);
      rst <= 1'b0;
      check_outputs();

      // fill every word, with strobe-less writes that must be dropped
      for (int a = 0; a < 2 ** ADDR_W; a++) begin
         edge_update();
         host_write(ADDR_W'(a), $urandom, STRB_W'($urandom_range(15, 1)));
         check_outputs();
         if ((a % 8) == 3) begin
            edge_update();
            host_write(ADDR_W'(a), $urandom, '0);
            check_outputs();
         end
      end
      idle_cycles(3);

      set_cfg(1, 16, 16, int'($urandom_range(1023, 0)), 0, 1, 0);
      do_run(1'b0, 1'b0, 1'b0, 1'b1);

      for (int k = 0; k < N_RAND; k++) begin
         set_cfg(int'($urandom_range(5, 1)), int'($urandom_range(8, 1)),
                 int'($urandom_range(9, 0)), int'($urandom_range(1023, 0)),
                 int'($urandom_range(1023, 0)), int'($urandom_range(1023, 0)),
                 int'($urandom_range(12, 0)));
         do_run(1'b0, $urandom_range(1, 0) == 1, $urandom_range(1, 0) == 1,
                $urandom_range(5, 0) != 0);
      end

      // address wrap at the top of memory
      set_cfg(3, 4, 4, 1020, 1000, 3, 2);
      do_run(1'b0, 1'b0, 1'b1, 1'b1);

      // gated output, then a disabled run pulse
      set_cfg(2, 5, 3, int'($urandom_range(1023, 0)), 7, 1, 1);
      do_run(1'b0, 1'b0, 1'b0, 1'b0);
      do_run(1'b1, 1'b0, 1'b0, 1'b1);

      set_cfg(2, 6, 4, int'($urandom_range(1023, 0)), 9, 2, 4);
      do_run(1'b0, 1'b1, 1'b0, 1'b1);

      // empty runs
      set_cfg(3, 4, 0, 5, 1, 1, 2);
      do_run(1'b0, 1'b0, 1'b0, 1'b1);
      set_cfg(3, 0, 2, 5, 1, 1, 0);
      do_run(1'b0, 1'b0, 1'b0, 1'b1);
      set_cfg(0, 4, 4, 5, 1, 1, 3);
      do_run(1'b0, 1'b0, 1'b0, 1'b1);

      set_cfg(2, 8, 8, int'($urandom_range(1023, 0)), 16, 1, 3);
      do_run(1'b0, 1'b0, 1'b1, 1'b1);
      do_run(1'b0, 1'b0, 1'b1, 1'b1);
      idle_cycles(4);

      $display("Testbench passed");
      $finish;
   end

   initial begin
      #(TIMEOUT_CYC * 10);
      $display("Testbench failed");
      $fatal(1, "timeout, the test sequence did not complete");
   end

endmodule

// File: flist.f
stream_pkg.sv
mem_port_if.sv
addr_gen.sv
out_mem_unit.sv
dp_ram.sv
stream_top.sv
tb_stream_asserts.sv
tb_stream.sv

// File: Makefile
TOP = tb_stream

all: run

run:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert -Wall -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
